// File: hdl/nn_pkg.sv
`default_nettype none

package nn_pkg;

  // Network shape
  localparam int n_in  = 4;
  localparam int n_hid = 3;
  localparam int n_w1  = n_in * n_hid;

  // Calculation step counter
  localparam int step_w = 3;

  // Steps 0 to n_in-1 accumulate the hidden sums
  localparam logic [step_w-1:0] relu_step = 3'd4;
  localparam logic [step_w-1:0] out_step  = 3'd5;

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_calc,
    st_out
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/nn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module nn_ctrl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       in_valid_d,
  output logic                      calc,
  output logic [nn_pkg::step_w-1:0] step,
  output logic                      fire
);

  nn_pkg::ctrl_state_t state;
  nn_pkg::ctrl_state_t next_state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= nn_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      nn_pkg::st_idle: begin
        if (in_valid_d) begin
          next_state = nn_pkg::st_load;
        end
      end
      nn_pkg::st_load: begin
        // Calculation starts once the data strobe drops
        if (!in_valid_d) begin
          next_state = nn_pkg::st_calc;
        end
      end
      nn_pkg::st_calc: begin
        if (step == nn_pkg::out_step) begin
          next_state = nn_pkg::st_out;
        end
      end
      nn_pkg::st_out: begin
        next_state = nn_pkg::st_idle;
      end
      default: begin
        next_state = nn_pkg::st_idle;
      end
    endcase
  end

  // Step counter runs only inside the calculation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step <= '0;
    end else if (state == nn_pkg::st_calc && step != nn_pkg::out_step) begin
      step <= step + 1'b1;
    end else begin
      step <= '0;
    end
  end

  assign calc = (state == nn_pkg::st_calc);
  assign fire = (state == nn_pkg::st_out);

endmodule

`default_nettype wire

// File: hdl/nn_operand_store.sv
`timescale 1ns/1ps
`default_nettype none

module nn_operand_store #(
  parameter int data_w = 16
) (
  input  wire                                         clk,
  input  wire                                         rst_n,
  input  wire                                         in_valid_w1,
  input  wire                                         in_valid_w2,
  input  wire                                         in_valid_d,
  input  wire  [data_w-1:0]                           weight1,
  input  wire  [data_w-1:0]                           weight2,
  input  wire  [data_w-1:0]                           data_point,
  output logic [nn_pkg::n_w1-1:0][data_w-1:0]         w1,
  output logic [nn_pkg::n_hid-1:0][data_w-1:0]        w2,
  output logic [nn_pkg::n_in-1:0][data_w-1:0]         d
);

  // New word enters at the top index, oldest ends up at index 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w1 <= '0;
    end else if (in_valid_w1) begin
      w1 <= {weight1, w1[nn_pkg::n_w1-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w2 <= '0;
    end else if (in_valid_w2) begin
      w2 <= {weight2, w2[nn_pkg::n_hid-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d <= '0;
    end else if (in_valid_d) begin
      d <= {data_point, d[nn_pkg::n_in-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/nn_mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module nn_mac_lane #(
  parameter int data_w = 16,
  parameter int frac_w = 8
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      first,
  input  wire                      mac_en,
  input  wire                      relu_en,
  input  wire        [data_w-1:0]  x,
  input  wire        [data_w-1:0]  w,
  output logic       [data_w-1:0]  h
);

  logic signed [2*data_w-1:0] full;
  logic signed [2*data_w-1:0] shifted;
  logic        [data_w-1:0]   prod;
  logic        [data_w-1:0]   acc;

  // Fixed-point product, truncated back to word width
  always_comb begin
    full    = $signed(x) * $signed(w);
    shifted = full >>> frac_w;
    prod    = shifted[data_w-1:0];
  end

  always_ff @(posedge clk) begin
    if (mac_en) begin
      acc <= first ? prod : acc + prod;
    end
  end

  // ReLU on the finished sum
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h <= '0;
    end else if (relu_en) begin
      h <= acc[data_w-1] ? '0 : acc;
    end
  end

endmodule

`default_nettype wire

// File: hdl/nn_hidden_layer.sv
`timescale 1ns/1ps
`default_nettype none

module nn_hidden_layer #(
  parameter int data_w = 16,
  parameter int frac_w = 8
) (
  input  wire                                          clk,
  input  wire                                          rst_n,
  input  wire                                          calc,
  input  wire  [nn_pkg::step_w-1:0]                    step,
  input  wire  [nn_pkg::n_w1-1:0][data_w-1:0]          w1,
  input  wire  [nn_pkg::n_in-1:0][data_w-1:0]          d,
  output logic [nn_pkg::n_hid-1:0][data_w-1:0]         h
);

  localparam int sel_w = $clog2(nn_pkg::n_in);

  logic             first;
  logic             mac_en;
  logic             relu_en;
  logic [sel_w-1:0] sel;

  // Step decode shared by all lanes
  assign first   = calc && (step == '0);
  assign mac_en  = calc && (step < nn_pkg::n_in);
  assign relu_en = calc && (step == nn_pkg::relu_step);
  assign sel     = step[sel_w-1:0];

  for (genvar lane = 0; lane < nn_pkg::n_hid; lane++) begin : g_lane
    nn_mac_lane #(
      .data_w (data_w),
      .frac_w (frac_w)
    ) u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .first   (first),
      .mac_en  (mac_en),
      .relu_en (relu_en),
      .x       (d[sel]),
      .w       (w1[lane*nn_pkg::n_in + sel]),
      .h       (h[lane])
    );
  end

endmodule

`default_nettype wire

// File: hdl/nn_output_neuron.sv
`timescale 1ns/1ps
`default_nettype none

module nn_output_neuron #(
  parameter int data_w = 16,
  parameter int frac_w = 8
) (
  input  wire                                          clk,
  input  wire                                          rst_n,
  input  wire                                          calc,
  input  wire  [nn_pkg::step_w-1:0]                    step,
  input  wire  [nn_pkg::n_hid-1:0][data_w-1:0]         h,
  input  wire  [nn_pkg::n_hid-1:0][data_w-1:0]         w2,
  output logic                                         out_valid,
  output logic [data_w-1:0]                            out
);

  logic [data_w-1:0] sum;
  logic              done;

  // Three products summed in one stage, wrapping at word width
  always_comb begin
    logic signed [2*data_w-1:0] full;
    logic signed [2*data_w-1:0] shifted;
    sum = '0;
    for (int j = 0; j < nn_pkg::n_hid; j++) begin
      full    = $signed(h[j]) * $signed(w2[j]);
      shifted = full >>> frac_w;
      sum     = sum + shifted[data_w-1:0];
    end
  end

  assign done = calc && (step == nn_pkg::out_step);

  // Output is zero outside its single valid cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out       <= '0;
    end else if (done) begin
      out_valid <= 1'b1;
      out       <= sum;
    end else begin
      out_valid <= 1'b0;
      out       <= '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/nn_top.sv
`timescale 1ns/1ps
`default_nettype none

module nn_top #(
  parameter int data_w = 16,
  parameter int frac_w = 8
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                in_valid_w1,
  input  wire                in_valid_w2,
  input  wire                in_valid_d,
  input  wire  [data_w-1:0]  weight1,
  input  wire  [data_w-1:0]  weight2,
  input  wire  [data_w-1:0]  data_point,
  output logic               out_valid,
  output logic [data_w-1:0]  out
);

  logic                                  calc;
  logic [nn_pkg::step_w-1:0]             step;
  logic [nn_pkg::n_w1-1:0][data_w-1:0]   w1;
  logic [nn_pkg::n_hid-1:0][data_w-1:0]  w2;
  logic [nn_pkg::n_in-1:0][data_w-1:0]   d;
  logic [nn_pkg::n_hid-1:0][data_w-1:0]  h;

  nn_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_d (in_valid_d),
    .calc       (calc),
    .step       (step),
    .fire       ()
  );

  nn_operand_store #(
    .data_w (data_w)
  ) u_store (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_w1 (in_valid_w1),
    .in_valid_w2 (in_valid_w2),
    .in_valid_d  (in_valid_d),
    .weight1     (weight1),
    .weight2     (weight2),
    .data_point  (data_point),
    .w1          (w1),
    .w2          (w2),
    .d           (d)
  );

  nn_hidden_layer #(
    .data_w (data_w),
    .frac_w (frac_w)
  ) u_hidden (
    .clk   (clk),
    .rst_n (rst_n),
    .calc  (calc),
    .step  (step),
    .w1    (w1),
    .d     (d),
    .h     (h)
  );

  nn_output_neuron #(
    .data_w (data_w),
    .frac_w (frac_w)
  ) u_output (
    .clk       (clk),
    .rst_n     (rst_n),
    .calc      (calc),
    .step      (step),
    .h         (h),
    .w2        (w2),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

`default_nettype wire

// File: test/nn_checker.sv
`timescale 1ns/1ps
`default_nettype none

module nn_checker #(
  parameter int data_w = 16
) (
  input wire              clk,
  input wire              rst_n,
  input wire              in_valid_d,
  input wire              out_valid,
  input wire [data_w-1:0] out
);

  string             name_q[$];
  logic [data_w-1:0] exp_q[$];
  int                pass_count = 0;
  int                fail_count = 0;
  int                error_count = 0;
  int                done_count = 0;
  // Edges left until out_valid is due, -1 when no data point is in flight
  int                wait_edges = -1;
  logic              prev_d = 1'b0;

  task automatic push_expected(input string name, input logic [data_w-1:0] value);
    name_q.push_back(name);
    exp_q.push_back(value);
  endtask

  task automatic check_reset_state(input string name);
    if (out_valid !== 1'b0 || out !== '0) begin
      $display("[FAIL] %s expected valid 0 out %h actual valid %b out %h",
               name, {data_w{1'b0}}, out_valid, out);
      fail_count++;
    end else begin
      $display("[PASS] %s valid 0 out %h", name, out);
      pass_count++;
    end
    done_count++;
  endtask

  task automatic finish_test();
    string             name;
    logic [data_w-1:0] expected;
    if (name_q.size() == 0) begin
      $display("out_valid was due but no expected value was queued");
      error_count++;
    end else begin
      name     = name_q.pop_front();
      expected = exp_q.pop_front();
      if (out_valid !== 1'b1) begin
        $display("%s: out_valid did not arrive 7 edges after the last data word", name);
        fail_count++;
      end else if (out !== expected) begin
        $display("[FAIL] %s expected %h actual %h", name, expected, out);
        fail_count++;
      end else begin
        $display("[PASS] %s out %h", name, out);
        pass_count++;
      end
      done_count++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (out_valid === 1'b0 && out !== '0) begin
        $display("out is %h while out_valid is low", out);
        error_count++;
      end
      if (wait_edges > 0) begin
        if (out_valid) begin
          $display("out_valid arrived %0d edges before it was due", wait_edges);
          error_count++;
        end
        wait_edges--;
      end else if (wait_edges == 0) begin
        finish_test();
        wait_edges = -1;
      end else if (out_valid) begin
        $display("out_valid went high with no data point loaded");
        error_count++;
      end
      // Last data word was stored on the previous edge
      if (prev_d && !in_valid_d) begin
        wait_edges = 6;
      end
    end
    prev_d = in_valid_d;
  end

endmodule

`default_nettype wire

// File: test/nn_assert.sv
`timescale 1ns/1ps
`default_nettype none

module nn_assert #(
  parameter int data_w = 16
) (
  input wire              clk,
  input wire              rst_n,
  input wire              in_valid_d,
  input wire              out_valid,
  input wire [data_w-1:0] out
);

  single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else $error("out_valid stayed high for two cycles");

  idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid |-> out == '0)
    else $error("out is nonzero while out_valid is low");

  // Fixed latency from the last data word
  data_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(in_valid_d) |-> ##7 out_valid)
    else $error("out_valid missing 7 edges after the last data word");

  valid_from_data: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> $past(in_valid_d, 8) && !$past(in_valid_d, 7))
    else $error("out_valid rose without a data point 7 edges earlier");

endmodule

bind nn_top nn_assert #(
  .data_w (data_w)
) u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid_d (in_valid_d),
  .out_valid  (out_valid),
  .out        (out)
);

`default_nettype wire

// File: test/tb_nn.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nn;

  localparam int data_w = 16;
  localparam int frac_w = 8;
  localparam int reset_cycles = 5;
  // Cycles per test beyond the words it loads
  localparam int test_overhead = 9;

  logic              clk = 1'b0;
  logic              rst_n = 1'b0;
  logic              in_valid_w1 = 1'b0;
  logic              in_valid_w2 = 1'b0;
  logic              in_valid_d = 1'b0;
  logic [data_w-1:0] weight1 = '0;
  logic [data_w-1:0] weight2 = '0;
  logic [data_w-1:0] data_point = '0;
  wire               out_valid;
  wire  [data_w-1:0] out;

  string             line_q[$];
  logic [data_w-1:0] word_buf [0:11];
  int                cycle_count = 0;
  int                cycle_limit = 1000;
  int                issued = 0;
  int                format_errors = 0;

  nn_top #(
    .data_w (data_w),
    .frac_w (frac_w)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_w1 (in_valid_w1),
    .in_valid_w2 (in_valid_w2),
    .in_valid_d  (in_valid_d),
    .weight1     (weight1),
    .weight2     (weight2),
    .data_point  (data_point),
    .out_valid   (out_valid),
    .out         (out)
  );

  nn_checker #(
    .data_w (data_w)
  ) u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_d (in_valid_d),
    .out_valid  (out_valid),
    .out        (out)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, a test never finished", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // Keeps the non-comment lines and sizes the timeout from them
  function automatic bit read_patterns();
    int    fd;
    int    words = 0;
    int    tests = 0;
    string line;
    string tag;
    fd = $fopen("test/nn_patterns.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
        line_q.push_back(line);
        void'($sscanf(line, "%s", tag));
        if (tag == "W1") begin
          words += 12;
        end else if (tag == "W2") begin
          words += 3;
        end else if (tag == "D") begin
          words += 4;
          tests++;
        end
      end
    end
    $fclose(fd);
    cycle_limit = 2 * (words + test_overhead * tests) + reset_cycles;
    return 1'b1;
  endfunction

  // kind 0 shifts weight1, 1 shifts weight2, 2 shifts data_point
  task automatic shift_words(input int kind, input int count);
    for (int k = 0; k < count; k++) begin
      @(posedge clk);
      #1;
      in_valid_w1 = (kind == 0);
      in_valid_w2 = (kind == 1);
      in_valid_d  = (kind == 2);
      weight1     = word_buf[k];
      weight2     = word_buf[k];
      data_point  = word_buf[k];
    end
    @(posedge clk);
    #1;
    in_valid_w1 = 1'b0;
    in_valid_w2 = 1'b0;
    in_valid_d  = 1'b0;
  endtask

  task automatic run_line(input string line);
    string             tag;
    string             name;
    logic [data_w-1:0] expected;
    int                n;
    void'($sscanf(line, "%s", tag));
    if (tag == "W1") begin
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                  word_buf[0], word_buf[1], word_buf[2], word_buf[3],
                  word_buf[4], word_buf[5], word_buf[6], word_buf[7],
                  word_buf[8], word_buf[9], word_buf[10], word_buf[11]);
      if (n == 13) begin
        shift_words(0, 12);
      end else begin
        $display("W1 line does not hold twelve words: %s", line);
        format_errors++;
      end
    end else if (tag == "W2") begin
      n = $sscanf(line, "%s %h %h %h", tag, word_buf[0], word_buf[1], word_buf[2]);
      if (n == 4) begin
        shift_words(1, 3);
      end else begin
        $display("W2 line does not hold three words: %s", line);
        format_errors++;
      end
    end else if (tag == "D") begin
      n = $sscanf(line, "%s %s %h %h %h %h %h", tag, name, word_buf[0],
                  word_buf[1], word_buf[2], word_buf[3], expected);
      if (n == 7) begin
        u_checker.push_expected(name, expected);
        issued++;
        shift_words(2, 4);
        while (u_checker.done_count < issued) begin
          @(posedge clk);
          #1;
        end
      end else begin
        $display("D line is missing a name, a data word or the result: %s", line);
        format_errors++;
      end
    end else begin
      $display("Unknown line in the patterns file: %s", line);
      format_errors++;
    end
  endtask

  initial begin
    if (!read_patterns()) begin
      $display("Could not open test/nn_patterns.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      issued++;
      u_checker.check_reset_state("reset_idle");
      foreach (line_q[i]) begin
        run_line(line_q[i]);
      end
      @(posedge clk);
      #1;
      $display("Tests: %0d, passed: %0d, failed: %0d, other errors: %0d",
               u_checker.done_count, u_checker.pass_count, u_checker.fail_count,
               u_checker.error_count + format_errors);
      if (u_checker.fail_count == 0 && u_checker.error_count == 0 &&
          format_errors == 0 && u_checker.done_count == issued && issued > 1) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/nn_patterns.txt
# W1: twelve hex weights, w1[0] first, index lane*4+input
# W2: three hex weights, w2[0] first
# D: test name, four hex data words d[0] first, expected hex output
# Words are 16-bit Q8.8 fixed point
W1 0100 0080 0040 0000 0080 0080 0080 0080 0200 0000 0000 0100
W2 0100 0080 0040
D pos_weights 0100 0200 0080 0400 0580
W1 0100 ff00 0000 0000 ff80 0000 0100 0000 0040 0040 0040 0040
W2 0100 0100 0200
D relu_one_neg 0100 0300 0100 0100 0380
D relu_two_neg_persist 0100 0200 0040 0080 01e0
W1 0010 0020 0030 0040 0050 0060 0070 0080 0090 00a0 00b0 00c0
W2 0100 0200 0300
D shift_order 0100 0200 0300 0400 1f40
W1 6000 0100 0000 0000 0100 fd00 0000 0000 0000 0000 0200 0100
D neg_data_wrap 0300 fe00 7000 3000 6000
W2 ff00 0100 0100
D neg_output 0300 fe00 7000 3000 fb00

// File: filelist.f
hdl/nn_pkg.sv
hdl/nn_ctrl.sv
hdl/nn_operand_store.sv
hdl/nn_mac_lane.sv
hdl/nn_hidden_layer.sv
hdl/nn_output_neuron.sv
hdl/nn_top.sv
test/nn_checker.sv
test/nn_assert.sv
test/tb_nn.sv

// File: Bender.yml
package:
  name: nn_infer

sources:
  - hdl/nn_pkg.sv
  - hdl/nn_ctrl.sv
  - hdl/nn_operand_store.sv
  - hdl/nn_mac_lane.sv
  - hdl/nn_hidden_layer.sv
  - hdl/nn_output_neuron.sv
  - hdl/nn_top.sv
  - target: test
    files:
      - test/nn_checker.sv
      - test/nn_assert.sv
      - test/tb_nn.sv
